// File: verilog.f
+incdir+src
src/ddrAxiPkg.sv
src/memTestPkg.sv
src/ddrResetSequencer.sv
src/burstSequencer.sv
src/laneChecker.sv
src/resultCollector.sv
src/memTesterTop.sv
testbench/axiMemModel.sv
testbench/tb_memTesterTop.sv

// File: Bender.yml
package:
  name: memTester

sources:
  - include_dirs:
      - src
    files:
      - src/ddrAxiPkg.sv
      - src/memTestPkg.sv
      - src/ddrResetSequencer.sv
      - src/burstSequencer.sv
      - src/laneChecker.sv
      - src/resultCollector.sv
      - src/memTesterTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/axiMemModel.sv
      - testbench/tb_memTesterTop.sv

// File: testbench/tb_memTesterTop.sv
//----------------------------------------------------------------------
// memory tester testbench with bring-up, axi protocol, pattern and errors
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module tb_memTesterTop
	import ddrAxiPkg::*;
();

// worst case run with heavy stalls times four runs times two
localparam int lpRunCycles = 200 + 2 * `MT_BURSTS * 2 * (`MT_BURST_LEN + 2) * 8;
localparam int lpTimeout   = 4 * lpRunCycles * 2;

logic         iACLK;
logic         pbSw0;
logic [2:0]   pllLocked;
logic         cfgDone, cfgReset, cfgStart, axiRstn;
logic         awready, wready, bvalid, arready, rvalid, rlast;
axiResp_t     bresp, rresp;
ddrAddr_t     awaddr, araddr, failAddr;
logic [7:0]   awlen, arlen;
logic [2:0]   awsize, arsize;
axiBurst_t    awburst, arburst;
logic         awvalid, wlast, wvalid, bready, arvalid, rready;
logic [255:0] wdata, rdata;
logic [31:0]  wstrb;
logic [7:2]   led;
logic         flipEn, errEn;
logic [31:0]  flipBeat, errBurst;
logic [7:0]   flipBit;
int           cycleCount;

memTesterTop DUT (
	.iACLK (iACLK), .i_pbSw0 (pbSw0), .i_pllLocked (pllLocked),
	.i_cfgDone (cfgDone), .o_cfgReset (cfgReset), .o_cfgStart (cfgStart),
	.o_axiRstn (axiRstn),
	.i_awready (awready), .i_wready (wready), .i_bvalid (bvalid), .i_bresp (bresp),
	.o_awaddr (awaddr), .o_awlen (awlen), .o_awsize (awsize), .o_awburst (awburst),
	.o_awvalid (awvalid), .o_wdata (wdata), .o_wstrb (wstrb), .o_wlast (wlast),
	.o_wvalid (wvalid), .o_bready (bready),
	.i_arready (arready), .i_rvalid (rvalid), .i_rlast (rlast), .i_rdata (rdata),
	.i_rresp (rresp), .o_araddr (araddr), .o_arlen (arlen), .o_arsize (arsize),
	.o_arburst (arburst), .o_arvalid (arvalid), .o_rready (rready),
	.o_led (led), .o_failAddr (failAddr)
);

axiMemModel uMem (
	.iACLK (iACLK), .qLocked (pbSw0), .i_cfgStart (cfgStart), .o_cfgDone (cfgDone),
	.i_awaddr (awaddr), .i_awvalid (awvalid), .o_awready (awready),
	.i_wdata (wdata), .i_wlast (wlast), .i_wvalid (wvalid), .o_wready (wready),
	.o_bvalid (bvalid), .o_bresp (bresp), .i_bready (bready),
	.i_araddr (araddr), .i_arvalid (arvalid), .o_arready (arready),
	.o_rvalid (rvalid), .o_rdata (rdata), .o_rlast (rlast), .o_rresp (rresp),
	.i_rready (rready),
	.i_flipEn (flipEn), .i_flipBeat (flipBeat), .i_flipBit (flipBit),
	.i_errEn (errEn), .i_errBurst (errBurst)
);

always #4 iACLK = ~iACLK;

//----------------------------------------------------------------------
// failure reporting
task stopRun();
	$display("tests failed");
	$fatal(1);
endtask

task failValue(input string name, input logic [255:0] exp, input logic [255:0] act);
	$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
	stopRun();
endtask

task failText(input string what);
	$display("ERROR at %0t ns: %s", $time, what);
	stopRun();
endtask

// lane word is address xor lane key and inverted in pass 1
function automatic logic [255:0] expectedBeat(input logic [32:0] addr, input bit inv);
	logic [255:0] beat;
	logic [31:0]  w;
	for (int l = 0; l < `MT_LANES; l++)
	begin
		w = addr[31:0] ^ (l * 32'h1111_1111);
		beat[l*32 +: 32] = inv ? ~w : w;
	end
	return beat;
endfunction

//----------------------------------------------------------------------
// protocol and sequencing checks sampled mid cycle
int           rstCnt, waitCnt, syncCnt, awCount, arCount, wBeat;
logic         startSeen, pReset, pStart, pAwvalid, pAwready, pWvalid, pWready;
logic         pArvalid, pArready, pWlast, bWait, rWait;
ddrAddr_t     pAwaddr, pAraddr, wAddr;
logic [255:0] pWdata;

always @(negedge iACLK)
begin
	if (!pbSw0)
	begin
		{rstCnt, waitCnt, syncCnt, awCount, arCount, wBeat} = '0;
		{startSeen, pStart, pAwvalid, pWvalid, pArvalid} = '0;
		{bWait, rWait} = '0;
		pReset = 1'b1;
	end
	else
	begin
		// bring-up timing
		if (cfgReset && led[2])
			rstCnt++;
		if (pReset && !cfgReset)
			assert (rstCnt == `MT_CFG_RST_CYCLES)
				else failValue("o_cfgReset high cycles", `MT_CFG_RST_CYCLES, rstCnt);
		if (!cfgReset && !cfgStart && !startSeen)
			waitCnt++;
		if (cfgStart && !startSeen)
		begin
			startSeen = 1'b1;
			assert (waitCnt == `MT_CFG_WAIT_CYCLES)
				else failValue("cycles before o_cfgStart", `MT_CFG_WAIT_CYCLES, waitCnt);
		end
		if (pStart && !cfgStart)
			assert (cfgDone) else failText("o_cfgStart fell before cfg done was given");
		assert (!axiRstn || cfgDone) else failText("o_axiRstn released before cfg done");
		assert (!(awvalid || wvalid || arvalid) || axiRstn)
			else failText("an AXI valid rose while o_axiRstn was low");
		// bring-up leds follow start and the axi reset release
		assert (led[3] == cfgStart) else failValue("cfgStart led", cfgStart, led[3]);
		assert (led[4] == axiRstn) else failValue("cfgDoneSync led", axiRstn, led[4]);
		// valid holds with a stable payload until ready
		if (pAwvalid && !pAwready)
		begin
			assert (awvalid) else failText("o_awvalid dropped without awready");
			assert (awaddr == pAwaddr) else failValue("o_awaddr", pAwaddr, awaddr);
		end
		if (pWvalid && !pWready)
		begin
			assert (wvalid) else failText("o_wvalid dropped without wready");
			assert (wdata == pWdata) else failValue("o_wdata", pWdata, wdata);
			assert (wlast == pWlast) else failValue("o_wlast", pWlast, wlast);
		end
		if (pArvalid && !pArready)
		begin
			assert (arvalid) else failText("o_arvalid dropped without arready");
			assert (araddr == pAraddr) else failValue("o_araddr", pAraddr, araddr);
		end
		// ready held through the response and read data phases
		if (bWait)
			assert (bready) else failValue("o_bready", 1, bready);
		if (rWait)
			assert (rready) else failValue("o_rready", 1, rready);
		if (wvalid && wready && wlast)
			bWait = 1'b1;
		else if (bvalid && bready)
			bWait = 1'b0;
		if (arvalid && arready)
			rWait = 1'b1;
		else if (rvalid && rready && rlast)
			rWait = 1'b0;
		// write bursts in region order
		if (awvalid && awready)
		begin
			assert (awaddr == (awCount % `MT_BURSTS) * `MT_BURST_BYTES)
				else failValue("o_awaddr", (awCount % `MT_BURSTS) * `MT_BURST_BYTES, awaddr);
			assert (awlen == `MT_BURST_LEN - 1) else failValue("o_awlen", 15, awlen);
			assert (awsize == 3'd5) else failValue("o_awsize", 5, awsize);
			assert (awburst == INCR) else failValue("o_awburst", INCR, awburst);
			awCount++;
		end
		// write beats against the pattern rule
		if (wvalid && wready)
		begin
			wAddr = ((awCount - 1) % `MT_BURSTS) * `MT_BURST_BYTES + wBeat * 32;
			assert (wlast == (wBeat == `MT_BURST_LEN - 1))
				else failValue("o_wlast", wBeat == `MT_BURST_LEN - 1, wlast);
			assert (wstrb == '1) else failValue("o_wstrb", 32'hffff_ffff, wstrb);
			assert (wdata == expectedBeat(wAddr, awCount > `MT_BURSTS))
				else failValue("o_wdata", expectedBeat(wAddr, awCount > `MT_BURSTS), wdata);
			wBeat = (wBeat == `MT_BURST_LEN - 1) ? 0 : wBeat + 1;
		end
		if (arvalid && arready)
		begin
			assert (araddr == (arCount % `MT_BURSTS) * `MT_BURST_BYTES)
				else failValue("o_araddr", (arCount % `MT_BURSTS) * `MT_BURST_BYTES, araddr);
			assert (arlen == `MT_BURST_LEN - 1) else failValue("o_arlen", 15, arlen);
			assert (arsize == 3'd5) else failValue("o_arsize", 5, arsize);
			assert (arburst == INCR) else failValue("o_arburst", INCR, arburst);
			arCount++;
		end
		// run from start until done and never both at once
		assert (!(led[5] && led[6])) else failText("testRun and testDone high together");
		if (led[4] && syncCnt < 3)
			syncCnt++;
		if (syncCnt >= 2 && !led[6])
		begin
			assert (led[5]) else failValue("testRun led", 1, led[5]);
		end
		else if (syncCnt < 2)
		begin
			assert (!led[5]) else failValue("testRun led before start", 0, led[5]);
		end
		pReset   = cfgReset;
		pStart   = cfgStart;
		pAwvalid = awvalid;
		pAwready = awready;
		pAwaddr  = awaddr;
		pWvalid  = wvalid;
		pWready  = wready;
		pWdata   = wdata;
		pWlast   = wlast;
		pArvalid = arvalid;
		pArready = arready;
		pAraddr  = araddr;
	end
end

//----------------------------------------------------------------------
// run control
always @(posedge iACLK)
begin
	cycleCount++;
	if (cycleCount > lpTimeout)
		failText("timeout, the test runs did not complete");
end

task restartRun();
	@(posedge iACLK);
	#1 pbSw0 = 1'b0;
	repeat (5) @(posedge iACLK);
	#1 pbSw0 = 1'b1;
endtask

task waitDone();
	while (!led[6])
		@(posedge iACLK);
	@(negedge iACLK);
endtask

initial
begin
	iACLK      = 1'b0;
	pbSw0      = 1'b0;
	pllLocked  = 3'b111;
	flipEn     = 1'b0;
	flipBeat   = 32'd37;
	flipBit    = 8'd101;
	errEn      = 1'b0;
	errBurst   = 32'd5;
	cycleCount = 0;
	repeat (5) @(posedge iACLK);
	#1 pbSw0 = 1'b1;
	// clean run
	waitDone();
	assert (!led[7]) else failValue("testFail led, clean run", 0, led[7]);
	// one flipped bit in lane 3 during pass 0
	flipEn = 1'b1;
	restartRun();
	waitDone();
	assert (led[7]) else failValue("testFail led, data error", 1, led[7]);
	assert (failAddr == flipBeat * 32) else failValue("o_failAddr", flipBeat * 32, failAddr);
	// one slverr write response
	flipEn = 1'b0;
	errEn  = 1'b1;
	restartRun();
	waitDone();
	assert (led[7]) else failValue("testFail led, response error", 1, led[7]);
	// clean again so fail must clear with reset
	errEn = 1'b0;
	restartRun();
	waitDone();
	assert (!led[7]) else failValue("testFail led, final run", 0, led[7]);
	$display("all tests passed");
	$finish;
end

endmodule

`default_nettype wire

// File: testbench/axiMemModel.sv
//----------------------------------------------------------------------
// axi4 slave memory model with ready stalls and error injection
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axiMemModel
	import ddrAxiPkg::*;
(
	input  wire          iACLK,
	input  wire          qLocked,
	// configuration
	input  wire          i_cfgStart,
	output logic         o_cfgDone,
	// write
	input  wire [32:0]   i_awaddr,
	input  wire          i_awvalid,
	output logic         o_awready,
	input  wire [255:0]  i_wdata,
	input  wire          i_wlast,
	input  wire          i_wvalid,
	output logic         o_wready,
	output logic         o_bvalid,
	output axiResp_t     o_bresp,
	input  wire          i_bready,
	// read
	input  wire [32:0]   i_araddr,
	input  wire          i_arvalid,
	output logic         o_arready,
	output logic         o_rvalid,
	output logic [255:0] o_rdata,
	output logic         o_rlast,
	output axiResp_t     o_rresp,
	input  wire          i_rready,
	// injection
	input  wire          i_flipEn,
	input  wire [31:0]   i_flipBeat,
	input  wire [7:0]    i_flipBit,
	input  wire          i_errEn,
	input  wire [31:0]   i_errBurst
);

// sparse store, one 256 bit word per beat index
logic [255:0] mem [int];
logic [31:0]  rndState;
int           wBase, wCnt, rBase, rCnt, bCount, doneWait;
logic         bPending, rActive, startSeen, flipUsed, errUsed;
logic         nCfgDone, nAwready, nWready, nBvalid, nArready, nRvalid, nRlast;
axiResp_t     nBresp;
logic [255:0] nRdata, word;

function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] s;
	s = x ^ (x << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

// three out of four cycles ready
function logic randomReady();
	rndState = xorshift(rndState);
	return rndState[1:0] != 2'b00;
endfunction

initial
begin
	rndState = 32'h6c366981;
	{o_cfgDone, o_awready, o_wready, o_bvalid, o_arready, o_rvalid, o_rlast} = '0;
	o_bresp = OKAY;
	o_rresp = OKAY;
	o_rdata = '0;
	{nCfgDone, nAwready, nWready, nBvalid, nArready, nRvalid, nRlast} = '0;
	nBresp = OKAY;
	nRdata = '0;
	{bPending, rActive, startSeen, flipUsed, errUsed} = '0;
	{wBase, wCnt, rBase, rCnt, bCount, doneWait} = '0;
end

//----------------------------------------------------------------------
// next state from what the dut sees at the coming edge
always @(negedge iACLK)
begin
	if (!qLocked)
	begin
		{nCfgDone, nAwready, nWready, nBvalid, nArready, nRvalid, nRlast} = '0;
		{bPending, rActive, startSeen, flipUsed, errUsed} = '0;
		bCount = 0;
		nBresp = OKAY;
	end
	else
	begin
		// cfg done a random 3 to 10 cycles after start
		if (!o_cfgDone && i_cfgStart)
		begin
			if (!startSeen)
			begin
				rndState  = xorshift(rndState);
				doneWait  = 3 + (rndState % 8);
				startSeen = 1'b1;
			end
			else if (doneWait <= 1)
				nCfgDone = 1'b1;
			else
				doneWait = doneWait - 1;
		end
		// write address and data
		if (o_awready && i_awvalid)
		begin
			wBase = i_awaddr >> 5;
			wCnt  = 0;
		end
		if (o_wready && i_wvalid)
		begin
			word = i_wdata;
			if (i_flipEn && !flipUsed && (wBase + wCnt == i_flipBeat))
			begin
				word[i_flipBit] = ~word[i_flipBit];
				flipUsed = 1'b1;
			end
			mem[wBase + wCnt] = word;
			wCnt = wCnt + 1;
			if (i_wlast)
				bPending = 1'b1;
		end
		nAwready = randomReady();
		nWready  = randomReady();
		// write response, held until bready
		if (o_bvalid && i_bready)
			nBvalid = 1'b0;
		else if (o_bvalid)
			nBvalid = 1'b1;
		else if (bPending && randomReady())
		begin
			nBvalid  = 1'b1;
			bPending = 1'b0;
			nBresp   = OKAY;
			if (i_errEn && !errUsed && bCount == i_errBurst)
			begin
				nBresp  = SLVERR;
				errUsed = 1'b1;
			end
			bCount = bCount + 1;
		end
		// read address
		if (o_arready && i_arvalid)
		begin
			rBase   = i_araddr >> 5;
			rCnt    = 0;
			rActive = 1'b1;
		end
		nArready = randomReady();
		// read data
		if (o_rvalid && i_rready)
		begin
			rCnt = rCnt + 1;
			if (o_rlast)
				rActive = 1'b0;
		end
		if (o_rvalid && !i_rready)
			nRvalid = 1'b1;
		else if (rActive && randomReady())
		begin
			nRvalid = 1'b1;
			nRdata  = mem.exists(rBase + rCnt) ? mem[rBase + rCnt] : '0;
			nRlast  = (rCnt == 15);
		end
		else
			nRvalid = 1'b0;
	end
end

// outputs change shortly after the rising edge
always @(posedge iACLK)
begin
	#1;
	o_cfgDone = nCfgDone;
	o_awready = nAwready;
	o_wready  = nWready;
	o_bvalid  = nBvalid;
	o_bresp   = nBresp;
	o_arready = nArready;
	o_rvalid  = nRvalid;
	o_rdata   = nRdata;
	o_rlast   = nRlast;
end

endmodule

`default_nettype wire

// File: src/memTesterTop.sv
//----------------------------------------------------------------------
// lpddr4x self-test board top
// lock reset, hard ip bring-up, axi4 lane test and status leds
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module memTesterTop
	import ddrAxiPkg::*;
	import memTestPkg::*;
(
	input  wire                        iACLK,
	input  wire                        i_pbSw0,
	input  wire [2:0]                  i_pllLocked,
	// hard ip configuration
	input  wire                        i_cfgDone,
	output logic                       o_cfgReset,
	output logic                       o_cfgStart,
	output logic                       o_axiRstn,
	// axi4 write
	input  wire                        i_awready,
	input  wire                        i_wready,
	input  wire                        i_bvalid,
	input  var axiResp_t               i_bresp,
	output ddrAddr_t                   o_awaddr,
	output logic [7:0]                 o_awlen,
	output logic [2:0]                 o_awsize,
	output axiBurst_t                  o_awburst,
	output logic                       o_awvalid,
	output wire [`MT_BUS_WIDTH-1:0]    o_wdata,
	output logic [`MT_BEAT_BYTES-1:0]  o_wstrb,
	output logic                       o_wlast,
	output logic                       o_wvalid,
	output logic                       o_bready,
	// axi4 read
	input  wire                        i_arready,
	input  wire                        i_rvalid,
	input  wire                        i_rlast,
	input  wire [`MT_BUS_WIDTH-1:0]    i_rdata,
	input  var axiResp_t               i_rresp,
	output ddrAddr_t                   o_araddr,
	output logic [7:0]                 o_arlen,
	output logic [2:0]                 o_arsize,
	output axiBurst_t                  o_arburst,
	output logic                       o_arvalid,
	output logic                       o_rready,
	// board
	output logic [7:2]                 o_led,
	output ddrAddr_t                   o_failAddr
);

//----------------------------------------------------------------------
// reset from push button and the three pll locks
logic qLocked;
logic rAReset, rnAReset;

assign qLocked = &{i_pbSw0, i_pllLocked};

always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
	begin
		rAReset  <= 1'b1;
		rnAReset <= 1'b0;
	end
	else
	begin
		rAReset  <= 1'b0;
		rnAReset <= 1'b1;
	end
end

//----------------------------------------------------------------------
// hard ip bring-up
logic wCfgDoneSync;

ddrResetSequencer uResetSeq (
	.iACLK         (iACLK),
	.qLocked       (rnAReset),
	.i_cfgDone     (i_cfgDone),
	.o_cfgReset    (o_cfgReset),
	.o_cfgStart    (o_cfgStart),
	.o_axiRstn     (o_axiRstn),
	.o_cfgDoneSync (wCfgDoneSync)
);

//----------------------------------------------------------------------
// burst sequencer, axi control only
ddrAddr_t  wBeatAddr;
testPass_t wPass;
logic      wRdBeat, wBBeat, wFinish;

burstSequencer uBurstSeq (
	.iACLK      (iACLK),       .qLocked   (rnAReset),
	.i_cfgDone  (wCfgDoneSync),
	.i_awready  (i_awready),   .i_wready  (i_wready),
	.i_bvalid   (i_bvalid),
	.o_awaddr   (o_awaddr),    .o_awlen   (o_awlen),
	.o_awsize   (o_awsize),    .o_awburst (o_awburst),
	.o_awvalid  (o_awvalid),   .o_wlast   (o_wlast),
	.o_wvalid   (o_wvalid),    .o_bready  (o_bready),
	.i_arready  (i_arready),   .i_rvalid  (i_rvalid),
	.i_rlast    (i_rlast),
	.o_araddr   (o_araddr),    .o_arlen   (o_arlen),
	.o_arsize   (o_arsize),    .o_arburst (o_arburst),
	.o_arvalid  (o_arvalid),   .o_rready  (o_rready),
	.o_beatAddr (wBeatAddr),   .o_pass    (wPass),
	.o_rdBeat   (wRdBeat),     .o_bBeat   (wBBeat),
	.o_finish   (wFinish)
);

// full beats only
assign o_wstrb = '1;

//----------------------------------------------------------------------
// lanes, each owns one 32 bit slice of wdata and rdata
wire [`MT_LANES-1:0] wMismatch;

for (genvar gi = 0; gi < `MT_LANES; gi++)
begin : gLane
	laneChecker #(
		.pLane (gi)
	) uLane (
		.iACLK      (iACLK),
		.qLocked    (rnAReset),
		.i_beatAddr (wBeatAddr),
		.i_pass     (wPass),
		.i_rdBeat   (wRdBeat),
		.i_rdWord   (i_rdata[gi*`MT_LANE_WIDTH +: `MT_LANE_WIDTH]),
		.o_wrWord   (o_wdata[gi*`MT_LANE_WIDTH +: `MT_LANE_WIDTH]),
		.o_mismatch (wMismatch[gi])
	);
end

//----------------------------------------------------------------------
// result
logic wTestRun, wTestDone, wTestFail;

resultCollector uResult (
	.iACLK      (iACLK),
	.qLocked    (rnAReset),
	.i_cfgDone  (wCfgDoneSync),
	.i_mismatch (wMismatch),
	.i_rdBeat   (wRdBeat),
	.i_bBeat    (wBBeat),
	.i_rresp    (i_rresp),
	.i_bresp    (i_bresp),
	.i_beatAddr (wBeatAddr),
	.i_finish   (wFinish),
	.o_testRun  (wTestRun),
	.o_testDone (wTestDone),
	.o_testFail (wTestFail),
	.o_failAddr (o_failAddr)
);

//----------------------------------------------------------------------
// user leds
// locked shows the registered lock
assign o_led[2] = ~rAReset;
assign o_led[3] = o_cfgStart;
assign o_led[4] = wCfgDoneSync;
assign o_led[5] = wTestRun;
assign o_led[6] = wTestDone;
assign o_led[7] = wTestFail;

endmodule

`default_nettype wire

// File: src/resultCollector.sv
//----------------------------------------------------------------------
// test status: run, done, sticky fail and first failing address
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module resultCollector
	import ddrAxiPkg::*;
(
	input  wire                 iACLK,
	input  wire                 qLocked,
	input  wire                 i_cfgDone,
	input  wire [`MT_LANES-1:0] i_mismatch,
	input  wire                 i_rdBeat,
	input  wire                 i_bBeat,
	input  var axiResp_t        i_rresp,
	input  var axiResp_t        i_bresp,
	input  var ddrAddr_t        i_beatAddr,
	input  wire                 i_finish,
	output logic                o_testRun,
	output logic                o_testDone,
	output logic                o_testFail,
	output ddrAddr_t            o_failAddr
);

logic     rCfgDoneD;
ddrAddr_t rAddrD;
logic     qStart, qLaneFail, qRespFail;

// start is the rising edge of cfg done
assign qStart    = i_cfgDone & ~rCfgDoneD;
assign qLaneFail = |i_mismatch;
assign qRespFail = (i_rdBeat & (i_rresp != OKAY)) | (i_bBeat & (i_bresp != OKAY));

// beat address delayed to line up with the lane flags
always_ff @(posedge iACLK)
begin
	rAddrD <= i_beatAddr;
end

//----------------------------------------------------------------------
always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
	begin
		rCfgDoneD  <= 1'b0;
		o_testRun  <= 1'b0;
		o_testDone <= 1'b0;
		o_testFail <= 1'b0;
		o_failAddr <= '0;
	end
	else
	begin
		rCfgDoneD <= i_cfgDone;
		if (qStart)
			o_testRun <= 1'b1;
		else if (i_finish)
			o_testRun <= 1'b0;
		if (i_finish)
			o_testDone <= 1'b1;
		// first failure only, the lane flag is the older event
		if (!o_testFail && (qLaneFail || qRespFail))
		begin
			o_testFail <= 1'b1;
			o_failAddr <= qLaneFail ? rAddrD : i_beatAddr;
		end
	end
end

endmodule

`default_nettype wire

// File: src/laneChecker.sv
//----------------------------------------------------------------------
// one 32 bit lane: write pattern out, check read data back
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module laneChecker
	import ddrAxiPkg::*;
	import memTestPkg::*;
#(
	parameter int pLane = 0
)(
	input  wire            iACLK,
	input  wire            qLocked,
	input  var ddrAddr_t   i_beatAddr,
	input  var testPass_t  i_pass,
	input  wire            i_rdBeat,
	input  var laneWord_t  i_rdWord,
	output laneWord_t      o_wrWord,
	output logic           o_mismatch
);

// lane key, L times 0x11111111
// keeps the eight lanes of one beat distinct
localparam laneWord_t lpLaneKey = laneWord_t'(pLane) * laneWord_t'(32'h1111_1111);

laneWord_t qSeed;
logic      qDiff;

//----------------------------------------------------------------------
// expected word for the current beat
assign qSeed    = laneWord_t'(i_beatAddr[31:0]) ^ lpLaneKey;
assign o_wrWord = (i_pass == INVERTED) ? ~qSeed : qSeed;

// read slice against expected
assign qDiff = (i_rdWord != o_wrWord);

//----------------------------------------------------------------------
// flag one cycle after the accepted r beat
always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
		o_mismatch <= 1'b0;
	else
		o_mismatch <= i_rdBeat & qDiff;
end

endmodule

`default_nettype wire

// File: src/burstSequencer.sv
//----------------------------------------------------------------------
// axi4 burst sequencer
// write then read the whole region, true pass then inverted pass
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module burstSequencer
	import ddrAxiPkg::*;
	import memTestPkg::*;
(
	input  wire        iACLK,
	input  wire        qLocked,
	input  wire        i_cfgDone,
	// write address / data / response
	input  wire        i_awready,
	input  wire        i_wready,
	input  wire        i_bvalid,
	output ddrAddr_t   o_awaddr,
	output logic [7:0] o_awlen,
	output logic [2:0] o_awsize,
	output axiBurst_t  o_awburst,
	output logic       o_awvalid,
	output logic       o_wlast,
	output logic       o_wvalid,
	output logic       o_bready,
	// read address / data
	input  wire        i_arready,
	input  wire        i_rvalid,
	input  wire        i_rlast,
	output ddrAddr_t   o_araddr,
	output logic [7:0] o_arlen,
	output logic [2:0] o_arsize,
	output axiBurst_t  o_arburst,
	output logic       o_arvalid,
	output logic       o_rready,
	// lane broadcast and strobes
	output ddrAddr_t   o_beatAddr,
	output testPass_t  o_pass,
	output logic       o_rdBeat,
	output logic       o_bBeat,
	output logic       o_finish
);

localparam int lpBeatW      = $clog2(`MT_BURST_LEN);
localparam int lpBurstW     = $clog2(`MT_BURSTS) + 1;
localparam int lpBeatShift  = $clog2(`MT_BEAT_BYTES);
localparam int lpBurstShift = $clog2(`MT_BURST_BYTES);

seqState_t           rState;
testPass_t           rPass;
logic [lpBurstW-1:0] rBurst;
logic [lpBeatW-1:0]  rBeat;
logic [1:0]          rDrain;
ddrAddr_t            qBurstBase;
logic                qAwHs, qWHs, qBHs, qArHs, qRHs;
logic                qLastBeat, qLastBurst;

//----------------------------------------------------------------------
// handshakes
assign qAwHs = o_awvalid & i_awready;
assign qWHs  = o_wvalid  & i_wready;
assign qBHs  = o_bready  & i_bvalid;
assign qArHs = o_arvalid & i_arready;
assign qRHs  = o_rready  & i_rvalid;

assign qLastBeat  = (rBeat  == lpBeatW'(`MT_BURST_LEN - 1));
assign qLastBurst = (rBurst == lpBurstW'(`MT_BURSTS - 1));

//----------------------------------------------------------------------
// burst fsm, any ready stall just holds the state
always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
	begin
		rState <= IDLE;
		rPass  <= TRUE_PATTERN;
		rBurst <= '0;
		rBeat  <= '0;
		rDrain <= '0;
	end
	else
	begin
		case (rState)
			IDLE:
			begin
				// one run per reset
				if (i_cfgDone)
					rState <= WR_ADDR;
			end
			WR_ADDR:
			begin
				if (qAwHs)
				begin
					rBeat  <= '0;
					rState <= WR_DATA;
				end
			end
			WR_DATA:
			begin
				// beat count stays on 15 through the response
				if (qWHs)
				begin
					if (qLastBeat)
						rState <= WR_RESP;
					else
						rBeat <= rBeat + 1'b1;
				end
			end
			WR_RESP:
			begin
				if (qBHs)
				begin
					if (qLastBurst)
					begin
						rBurst <= '0;
						rState <= RD_ADDR;
					end
					else
					begin
						rBurst <= rBurst + 1'b1;
						rState <= WR_ADDR;
					end
				end
			end
			RD_ADDR:
			begin
				if (qArHs)
				begin
					rBeat  <= '0;
					rState <= RD_DATA;
				end
			end
			RD_DATA:
			begin
				if (qRHs)
				begin
					if (!i_rlast)
						rBeat <= rBeat + 1'b1;
					else if (!qLastBurst)
					begin
						rBurst <= rBurst + 1'b1;
						rState <= RD_ADDR;
					end
					else if (rPass == TRUE_PATTERN)
					begin
						// second pass, inverted data
						rBurst <= '0;
						rPass  <= INVERTED;
						rState <= WR_ADDR;
					end
					else
						rState <= FINISH;
				end
			end
			FINISH:
			begin
				// let the last lane compare settle first
				if (rDrain != 2'd3)
					rDrain <= rDrain + 1'b1;
			end
			default:
				rState <= IDLE;
		endcase
	end
end

//----------------------------------------------------------------------
// address generation
assign qBurstBase = ddrAddr_t'(rBurst) << lpBurstShift;
assign o_beatAddr = qBurstBase + (ddrAddr_t'(rBeat) << lpBeatShift);
assign o_pass     = rPass;

// write channels
assign o_awaddr  = qBurstBase;
assign o_awlen   = 8'(`MT_BURST_LEN - 1);
assign o_awsize  = 3'(lpBeatShift);
assign o_awburst = INCR;
assign o_awvalid = (rState == WR_ADDR);
assign o_wvalid  = (rState == WR_DATA);
assign o_wlast   = (rState == WR_DATA) & qLastBeat;
assign o_bready  = (rState == WR_RESP);

// read channels, same burst shape
assign o_araddr  = qBurstBase;
assign o_arlen   = 8'(`MT_BURST_LEN - 1);
assign o_arsize  = 3'(lpBeatShift);
assign o_arburst = INCR;
assign o_arvalid = (rState == RD_ADDR);
assign o_rready  = (rState == RD_DATA);

// strobes
assign o_rdBeat = qRHs;
assign o_bBeat  = qBHs;
assign o_finish = (rState == FINISH) & (rDrain == 2'd2);

endmodule

`default_nettype wire

// File: src/ddrResetSequencer.sv
//----------------------------------------------------------------------
// hard controller bring-up
// config reset, settle wait, start until done, then axi reset release
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "memTester_defines.svh"

module ddrResetSequencer (
	input  wire  iACLK,
	input  wire  qLocked,
	input  wire  i_cfgDone,
	output logic o_cfgReset,
	output logic o_cfgStart,
	output logic o_axiRstn,
	output logic o_cfgDoneSync
);

// counter sized for the longer of the two phases
localparam int lpCntMax = (`MT_CFG_RST_CYCLES > `MT_CFG_WAIT_CYCLES) ?
	`MT_CFG_RST_CYCLES : `MT_CFG_WAIT_CYCLES;
localparam int lpCntW = $clog2(lpCntMax) + 1;

typedef enum logic [1:0]
{
	stCfgReset = 2'd0,
	stCfgWait  = 2'd1,
	stCfgStart = 2'd2,
	stCfgDone  = 2'd3
} rstState_t;

rstState_t         rState;
logic [lpCntW-1:0] rCnt;
logic              rDoneMeta, rDoneSync;
logic              rReady;

//----------------------------------------------------------------------
// cfg done comes from the hard ip, two flop sync
always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
	begin
		rDoneMeta <= 1'b0;
		rDoneSync <= 1'b0;
	end
	else
	begin
		rDoneMeta <= i_cfgDone;
		rDoneSync <= rDoneMeta;
	end
end

//----------------------------------------------------------------------
// bring-up fsm
always_ff @(posedge iACLK, negedge qLocked)
begin
	if (!qLocked)
	begin
		rState     <= stCfgReset;
		rCnt       <= '0;
		o_cfgReset <= 1'b1;
		o_cfgStart <= 1'b0;
		rReady     <= 1'b0;
	end
	else
	begin
		case (rState)
			stCfgReset:
			begin
				// hold config reset, drop it on the last count
				if (rCnt == lpCntW'(`MT_CFG_RST_CYCLES - 1))
				begin
					rCnt       <= '0;
					o_cfgReset <= 1'b0;
					rState     <= stCfgWait;
				end
				else
					rCnt <= rCnt + 1'b1;
			end
			stCfgWait:
			begin
				if (rCnt == lpCntW'(`MT_CFG_WAIT_CYCLES - 1))
				begin
					o_cfgStart <= 1'b1;
					rState     <= stCfgStart;
				end
				else
					rCnt <= rCnt + 1'b1;
			end
			stCfgStart:
			begin
				// start level stays until done is seen
				if (rDoneSync)
				begin
					o_cfgStart <= 1'b0;
					rState     <= stCfgDone;
				end
			end
			stCfgDone:
				rReady <= 1'b1;
			default:
				rState <= stCfgReset;
		endcase
	end
end

// axi reset release and done flag rise together
assign o_axiRstn     = rReady;
assign o_cfgDoneSync = rReady;

endmodule

`default_nettype wire

// File: src/memTestPkg.sv
//----------------------------------------------------------------------
// tester side types: burst fsm states, lane data word, pass select
//----------------------------------------------------------------------
`default_nettype none

`include "memTester_defines.svh"

package memTestPkg;

	// burst sequencer fsm
	typedef enum logic [2:0]
	{
		IDLE    = 3'd0,
		WR_ADDR = 3'd1,
		WR_DATA = 3'd2,
		WR_RESP = 3'd3,
		RD_ADDR = 3'd4,
		RD_DATA = 3'd5,
		FINISH  = 3'd6
	} seqState_t;

	// one lane slice of a beat
	typedef logic [`MT_LANE_WIDTH-1:0] laneWord_t;

	// pass 0 true pattern, pass 1 the inverse
	typedef enum logic
	{
		TRUE_PATTERN = 1'b0,
		INVERTED     = 1'b1
	} testPass_t;

endpackage

`default_nettype wire

// File: src/ddrAxiPkg.sv
//----------------------------------------------------------------------
// axi side types of the lpddr4x hard controller port
//----------------------------------------------------------------------
`default_nettype none

package ddrAxiPkg;

	// byte address
	// bit 32 is the chip select, [31:15] row, [14:12] bank, [11:2] col
	typedef logic [32:0] ddrAddr_t;

	// bresp / rresp codes
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axiResp_t;

	// burst type
	// only incr goes out on the bus
	typedef enum logic [1:0]
	{
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axiBurst_t;

endpackage

`default_nettype wire

// File: src/memTester_defines.svh
//----------------------------------------------------------------------
// memory tester constants
// bus and burst shape, test region size, bring-up timing
//----------------------------------------------------------------------
`ifndef MEMTESTER_DEFINES_SVH
`define MEMTESTER_DEFINES_SVH

// axi data path, split into 32 bit lanes
`define MT_BUS_WIDTH 256
`define MT_LANES 8
`define MT_LANE_WIDTH (`MT_BUS_WIDTH / `MT_LANES)
`define MT_BEAT_BYTES (`MT_BUS_WIDTH / 8)

// burst shape and test region, region starts at byte 0
`define MT_BURST_LEN 16
`define MT_BURSTS 8
`define MT_BURST_BYTES (`MT_BURST_LEN * `MT_BEAT_BYTES)

// hard ip bring-up, in aclk cycles
`define MT_CFG_RST_CYCLES 16
`define MT_CFG_WAIT_CYCLES 16

`endif
